//--- common/coh_macros.svh
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Cache geometry and bus widths
// for the MESI coherence subsystem
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`ifndef COH_MACROS_SVH
`define COH_MACROS_SVH

// Byte address and data word
`define COH_ADDR_W 32
`define COH_WORD_W 32

// Two words per line, direct mapped
`define COH_WORDS_PER_BLOCK 2
`define COH_NUM_SETS 8
`define COH_INDEX_W 3

// Byte offset within one block
`define COH_OFFSET_W 3

`endif

//--- common/coh_pkg.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Shared types of the coherence subsystem
//   vector typedefs, MESI, L2 and bus enums
//   request and response structs per port
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`include "coh_macros.svh"

package coh_pkg;

    typedef logic [`COH_ADDR_W-1:0] addr_t;
    typedef logic [`COH_WORD_W-1:0] word_t;
    // Word 0 sits at the lower address
    typedef word_t [`COH_WORDS_PER_BLOCK-1:0] block_t;
    typedef logic [`COH_ADDR_W-`COH_INDEX_W-`COH_OFFSET_W-1:0] tag_t;
    typedef logic [`COH_INDEX_W-1:0] index_t;

    typedef enum logic [1:0] {INVALID, SHARED, EXCLUSIVE, MODIFIED} mesi_t;
    typedef enum logic [1:0] {L2_FREE, L2_BUSY, L2_ACCESS} l2_state_t;
    typedef enum logic [2:0] {BUS_NONE, BUS_RD, BUS_RDX, BUS_INV, BUS_WB} bus_op_t;

    // Core side
    typedef struct packed {logic ren; logic wen; addr_t addr; word_t wdata;} cpu_req_t;
    typedef struct packed {logic busy; word_t rdata;} cpu_rsp_t;

    // Cache to coherence unit, victim attached
    typedef struct packed {
        logic   valid;
        logic   write;
        logic   upgrade;
        addr_t  addr;
        logic   victim_dirty;
        addr_t  victim_addr;
        block_t victim_data;
    } fill_req_t;
    typedef struct packed {logic done; mesi_t new_state; block_t data;} fill_rsp_t;

    // Coherence unit to bus sequencer
    typedef struct packed {bus_op_t kind; addr_t addr; block_t store;} bus_req_t;
    typedef struct packed {logic done; block_t load; logic shared;} bus_rsp_t;

    // Snoop in either direction
    typedef struct packed {logic valid; logic write; addr_t addr;} snoop_req_t;
    typedef struct packed {logic done; logic hit; logic dirty; block_t data;} snoop_rsp_t;

    // One word per L2 beat
    typedef struct packed {logic ren; logic wen; addr_t addr; word_t store;} l2_req_t;

endpackage

//--- l1_cache/l1_dcache.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Direct-mapped L1 data cache
//   data, tag and MESI state arrays
//   core-side FSM: lookup, respond, miss
//   combinational snoop lookup port
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`include "coh_macros.svh"

module l1_dcache (
    input  logic                CLK,
    input  logic                rst_n,
    input  coh_pkg::cpu_req_t   cpu_req,
    output coh_pkg::cpu_rsp_t   cpu_rsp,
    output coh_pkg::fill_req_t  fill_req,
    input  coh_pkg::fill_rsp_t  fill_rsp,
    input  coh_pkg::addr_t      snp_addr,
    output logic                snp_hit,
    output coh_pkg::mesi_t      snp_state,
    output coh_pkg::block_t     snp_data,
    input  logic                snp_upd,
    input  coh_pkg::mesi_t      snp_new_state
);
    import coh_pkg::*;

    typedef enum logic [1:0] {LOOKUP, RESPOND, MISS} dc_state_t;

    block_t    data_arr  [`COH_NUM_SETS];
    tag_t      tag_arr   [`COH_NUM_SETS];
    mesi_t     state_arr [`COH_NUM_SETS];

    dc_state_t state_q;
    index_t    req_idx;
    tag_t      req_tag;
    logic      req_word;
    index_t    snp_idx;
    logic      line_hit;
    mesi_t     line_state;
    logic      may_write;
    logic      conflict;
    logic      cpu_wr_done;

    // Address split for the core request
    assign req_idx  = cpu_req.addr[`COH_OFFSET_W +: `COH_INDEX_W];
    assign req_tag  = cpu_req.addr[`COH_ADDR_W-1 -: $bits(tag_t)];
    assign req_word = cpu_req.addr[`COH_OFFSET_W-1];
    assign snp_idx  = snp_addr[`COH_OFFSET_W +: `COH_INDEX_W];

    assign line_state = state_arr[req_idx];
    assign line_hit   = (line_state != INVALID) && (tag_arr[req_idx] == req_tag);
    // E and M lines take a write without bus traffic
    assign may_write  = (line_state == EXCLUSIVE) || (line_state == MODIFIED);

    // A snoop update on our set in the respond cycle wins, core retries
    assign conflict    = snp_upd && (snp_idx == req_idx);
    assign cpu_wr_done = (state_q == RESPOND) && cpu_req.wen && !conflict;

    assign cpu_rsp.busy  = (state_q != RESPOND) || conflict;
    assign cpu_rsp.rdata = data_arr[req_idx][req_word];

    // Miss or upgrade request, held for the whole MISS state
    assign fill_req.valid        = (state_q == MISS);
    assign fill_req.write        = cpu_req.wen;
    assign fill_req.upgrade      = cpu_req.wen && line_hit && (line_state == SHARED);
    assign fill_req.addr         = {req_tag, req_idx, {`COH_OFFSET_W{1'b0}}};
    // Only a Modified line of another tag needs writing back
    assign fill_req.victim_dirty = (line_state == MODIFIED) && (tag_arr[req_idx] != req_tag);
    assign fill_req.victim_addr  = {tag_arr[req_idx], req_idx, {`COH_OFFSET_W{1'b0}}};
    assign fill_req.victim_data  = data_arr[req_idx];

    // Snoop side reads the same arrays
    assign snp_state = state_arr[snp_idx];
    assign snp_hit   = (snp_state != INVALID) &&
                       (tag_arr[snp_idx] == snp_addr[`COH_ADDR_W-1 -: $bits(tag_t)]);
    assign snp_data  = data_arr[snp_idx];

    always_ff @(posedge CLK or negedge rst_n) begin
        if (!rst_n) begin
            state_q <= LOOKUP;
        end else begin
            case (state_q)
                LOOKUP: begin
                    if (cpu_req.ren || cpu_req.wen) begin
                        // Reads need a valid line, writes need ownership
                        if (line_hit && (cpu_req.ren || may_write))
                            state_q <= RESPOND;
                        else
                            state_q <= MISS;
                    end
                end
                // One cycle with busy low, or a retry on conflict
                RESPOND: state_q <= LOOKUP;
                // Look up again once the line is in place
                MISS: begin
                    if (fill_rsp.done)
                        state_q <= LOOKUP;
                end
                default: state_q <= LOOKUP;
            endcase
        end
    end

    // State array, later writes win so snoop updates come last
    always_ff @(posedge CLK or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < `COH_NUM_SETS; i++)
                state_arr[i] <= INVALID;
        end else begin
            if (cpu_wr_done)
                state_arr[req_idx] <= MODIFIED;
            if (fill_rsp.done)
                state_arr[req_idx] <= fill_rsp.new_state;
            if (snp_upd)
                state_arr[snp_idx] <= snp_new_state;
        end
    end

    // Data and tags
    always_ff @(posedge CLK) begin
        if (fill_rsp.done) begin
            tag_arr[req_idx] <= req_tag;
            // An upgrade keeps the data already held
            if (!fill_req.upgrade)
                data_arr[req_idx] <= fill_rsp.data;
        end
        if (cpu_wr_done)
            data_arr[req_idx][req_word] <= cpu_req.wdata;
    end

endmodule

//--- l1_cache/coherence_unit.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// MESI coherence unit
//   turns misses and upgrades into bus ops
//   answers inbound snoops in one cycle
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module coherence_unit (
    input  logic                 CLK,
    input  logic                 rst_n,
    input  coh_pkg::fill_req_t   fill_req,
    output coh_pkg::fill_rsp_t   fill_rsp,
    input  coh_pkg::snoop_req_t  snp_in,
    output coh_pkg::snoop_rsp_t  snp_out,
    output coh_pkg::addr_t       snp_addr,
    input  logic                 snp_hit,
    input  coh_pkg::mesi_t       snp_state,
    input  coh_pkg::block_t      snp_data,
    output logic                 snp_upd,
    output coh_pkg::mesi_t       snp_new_state,
    output coh_pkg::bus_req_t    bus_req,
    input  coh_pkg::bus_rsp_t    bus_rsp
);
    import coh_pkg::*;

    typedef enum logic [1:0] {CU_IDLE, CU_WB, CU_XFER} cu_state_t;

    cu_state_t state_q;
    fill_req_t req_q;
    logic      start;
    logic      snp_take;

    // Bus op that brings the line in with the right permission
    function automatic bus_op_t op_kind(input fill_req_t f);
        if (f.upgrade)
            return BUS_INV;
        if (f.write)
            return BUS_RDX;
        return BUS_RD;
    endfunction

    // Snoops go first when idle, so the fill sees the updated state
    assign snp_take = (state_q == CU_IDLE) && snp_in.valid;
    assign start    = (state_q == CU_IDLE) && fill_req.valid && !snp_in.valid;

    // Inbound snoop, answered straight from the arrays
    assign snp_addr      = snp_in.addr;
    assign snp_out.done  = snp_take;
    assign snp_out.hit   = snp_hit;
    assign snp_out.dirty = (snp_state == MODIFIED);
    assign snp_out.data  = snp_data;
    // Peer read leaves us Shared, peer write leaves us Invalid
    assign snp_upd       = snp_take && snp_hit;
    assign snp_new_state = snp_in.write ? INVALID : SHARED;

    // Shown in the start cycle already, so the bus sees no gap
    always_comb begin
        bus_req = '0;
        case (state_q)
            CU_IDLE: begin
                if (start) begin
                    bus_req.kind  = fill_req.victim_dirty ? BUS_WB : op_kind(fill_req);
                    bus_req.addr  = fill_req.victim_dirty ? fill_req.victim_addr :
                                    fill_req.addr;
                    bus_req.store = fill_req.victim_data;
                end
            end
            CU_WB: begin
                bus_req.kind  = BUS_WB;
                bus_req.addr  = req_q.victim_addr;
                bus_req.store = req_q.victim_data;
            end
            CU_XFER: begin
                bus_req.kind = op_kind(req_q);
                bus_req.addr = req_q.addr;
            end
            default: bus_req = '0;
        endcase
    end

    // Fill completes with the bus op, state picked from the response
    assign fill_rsp.done      = (state_q == CU_XFER) && bus_rsp.done;
    assign fill_rsp.new_state = req_q.write   ? MODIFIED :
                                bus_rsp.shared ? SHARED : EXCLUSIVE;
    assign fill_rsp.data      = bus_rsp.load;

    always_ff @(posedge CLK or negedge rst_n) begin
        if (!rst_n) begin
            state_q <= CU_IDLE;
        end else begin
            case (state_q)
                CU_IDLE: begin
                    if (start)
                        state_q <= fill_req.victim_dirty ? CU_WB : CU_XFER;
                end
                // Victim out first, then the line op
                CU_WB: begin
                    if (bus_rsp.done)
                        state_q <= CU_XFER;
                end
                CU_XFER: begin
                    if (bus_rsp.done)
                        state_q <= CU_IDLE;
                end
                default: state_q <= CU_IDLE;
            endcase
        end
    end

    // Request copy taken at start
    always_ff @(posedge CLK) begin
        if (start)
            req_q <= fill_req;
    end

endmodule

//--- logic/bus_ctrl.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Bus sequencer
//   local ops: peer snoop, then c2c or L2 beats
//   peer ops: local snoop, dirty write to L2
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`include "coh_macros.svh"

module bus_ctrl (
    input  logic                 CLK,
    input  logic                 rst_n,
    input  coh_pkg::bus_req_t    bus_req,
    output coh_pkg::bus_rsp_t    bus_rsp,
    output coh_pkg::snoop_req_t  local_snp,
    input  coh_pkg::snoop_rsp_t  local_snp_rsp,
    input  coh_pkg::snoop_req_t  peer_req,
    output coh_pkg::snoop_rsp_t  peer_rsp,
    output coh_pkg::snoop_req_t  peer_snoop,
    input  coh_pkg::snoop_rsp_t  peer_snoop_rsp,
    output coh_pkg::l2_req_t     l2_req,
    input  coh_pkg::l2_state_t   l2_state,
    input  coh_pkg::word_t       l2_load
);
    import coh_pkg::*;

    localparam int BEAT_W = $clog2(`COH_WORDS_PER_BLOCK);
    localparam logic [BEAT_W-1:0] LAST_BEAT = BEAT_W'(`COH_WORDS_PER_BLOCK - 1);

    typedef enum logic [2:0] {BC_IDLE, BC_SNOOP, BC_LSNP, BC_RD, BC_WR, BC_DONE} bc_state_t;

    bc_state_t         state_q;
    bus_op_t           kind_q;
    logic              peer_q;
    logic              hit_q;
    logic              dirty_q;
    logic [BEAT_W-1:0] beat_q;
    addr_t             addr_q;
    block_t            blk_q;
    logic              beat_ok;

    // A beat moves only in the ACCESS cycle
    assign beat_ok = (l2_state == L2_ACCESS);

    // Outbound snoop, write set for ownership and invalidation
    assign peer_snoop.valid = (state_q == BC_SNOOP);
    assign peer_snoop.write = (kind_q != BUS_RD);
    assign peer_snoop.addr  = addr_q;

    // Peer request goes to our own coherence unit
    assign local_snp.valid = (state_q == BC_LSNP);
    assign local_snp.write = peer_req.write;
    assign local_snp.addr  = peer_req.addr;

    // L2 word address from block base and beat
    assign l2_req.ren   = (state_q == BC_RD);
    assign l2_req.wen   = (state_q == BC_WR);
    assign l2_req.addr  = {addr_q[`COH_ADDR_W-1:`COH_OFFSET_W], beat_q, 2'b00};
    assign l2_req.store = blk_q[beat_q];

    // Only a peer read hit leaves the line shared
    assign bus_rsp.done   = (state_q == BC_DONE) && !peer_q;
    assign bus_rsp.load   = blk_q;
    assign bus_rsp.shared = hit_q && (kind_q == BUS_RD);

    assign peer_rsp.done  = (state_q == BC_DONE) && peer_q;
    assign peer_rsp.hit   = hit_q;
    assign peer_rsp.dirty = dirty_q;
    assign peer_rsp.data  = blk_q;

    always_ff @(posedge CLK or negedge rst_n) begin
        if (!rst_n) begin
            state_q <= BC_IDLE;
            kind_q  <= BUS_NONE;
            peer_q  <= 1'b0;
            hit_q   <= 1'b0;
            dirty_q <= 1'b0;
            beat_q  <= '0;
        end else begin
            case (state_q)
                BC_IDLE: begin
                    beat_q <= '0;
                    // Local op first, the peer waits until we are free
                    if (bus_req.kind != BUS_NONE) begin
                        kind_q  <= bus_req.kind;
                        peer_q  <= 1'b0;
                        hit_q   <= 1'b0;
                        dirty_q <= 1'b0;
                        state_q <= (bus_req.kind == BUS_WB) ? BC_WR : BC_SNOOP;
                    end else if (peer_req.valid) begin
                        peer_q  <= 1'b1;
                        state_q <= BC_LSNP;
                    end
                end
                BC_SNOOP: begin
                    if (peer_snoop_rsp.done) begin
                        hit_q   <= peer_snoop_rsp.hit;
                        dirty_q <= peer_snoop_rsp.dirty;
                        if (kind_q == BUS_INV)
                            state_q <= BC_DONE;
                        else if (!peer_snoop_rsp.hit)
                            state_q <= BC_RD;
                        // Dirty peer data also goes to L2
                        else if (peer_snoop_rsp.dirty)
                            state_q <= BC_WR;
                        else
                            state_q <= BC_DONE;
                    end
                end
                BC_LSNP: begin
                    if (local_snp_rsp.done) begin
                        hit_q   <= local_snp_rsp.hit;
                        dirty_q <= local_snp_rsp.dirty;
                        if (local_snp_rsp.hit && local_snp_rsp.dirty)
                            state_q <= BC_WR;
                        else
                            state_q <= BC_DONE;
                    end
                end
                BC_RD, BC_WR: begin
                    if (beat_ok) begin
                        beat_q <= beat_q + 1'b1;
                        if (beat_q == LAST_BEAT)
                            state_q <= BC_DONE;
                    end
                end
                BC_DONE: state_q <= BC_IDLE;
                default: state_q <= BC_IDLE;
            endcase
        end
    end

    // Address and block buffer
    always_ff @(posedge CLK) begin
        if (state_q == BC_IDLE) begin
            if (bus_req.kind != BUS_NONE) begin
                addr_q <= bus_req.addr;
                blk_q  <= bus_req.store;
            end else begin
                addr_q <= peer_req.addr;
            end
        end
        // Cache-to-cache data from the peer
        if ((state_q == BC_SNOOP) && peer_snoop_rsp.done && peer_snoop_rsp.hit)
            blk_q <= peer_snoop_rsp.data;
        if ((state_q == BC_LSNP) && local_snp_rsp.done)
            blk_q <= local_snp_rsp.data;
        if ((state_q == BC_RD) && beat_ok)
            blk_q[beat_q] <= l2_load;
    end

endmodule

//--- logic/cache_coh_top.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Coherent L1 data cache, top level
//   cache, coherence unit, bus sequencer
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module cache_coh_top (
    input  logic                 CLK,
    input  logic                 rst_n,
    input  coh_pkg::cpu_req_t    cpu_req,
    output coh_pkg::cpu_rsp_t    cpu_rsp,
    input  coh_pkg::snoop_req_t  peer_req,
    output coh_pkg::snoop_rsp_t  peer_rsp,
    output coh_pkg::snoop_req_t  peer_snoop,
    input  coh_pkg::snoop_rsp_t  peer_snoop_rsp,
    output coh_pkg::l2_req_t     l2_req,
    input  coh_pkg::l2_state_t   l2_state,
    input  coh_pkg::word_t       l2_load
);
    import coh_pkg::*;

    // Cache to coherence unit
    fill_req_t  fill_req;
    fill_rsp_t  fill_rsp;
    addr_t      snp_addr;
    logic       snp_hit;
    mesi_t      snp_state;
    block_t     snp_data;
    logic       snp_upd;
    mesi_t      snp_new_state;

    // Coherence unit to bus sequencer
    bus_req_t   bus_req;
    bus_rsp_t   bus_rsp;
    snoop_req_t local_snp;
    snoop_rsp_t local_snp_rsp;

    l1_dcache l1_dcache_inst (
        .CLK           (CLK),
        .rst_n         (rst_n),
        .cpu_req       (cpu_req),
        .cpu_rsp       (cpu_rsp),
        .fill_req      (fill_req),
        .fill_rsp      (fill_rsp),
        .snp_addr      (snp_addr),
        .snp_hit       (snp_hit),
        .snp_state     (snp_state),
        .snp_data      (snp_data),
        .snp_upd       (snp_upd),
        .snp_new_state (snp_new_state)
    );

    coherence_unit coherence_unit_inst (
        .CLK           (CLK),
        .rst_n         (rst_n),
        .fill_req      (fill_req),
        .fill_rsp      (fill_rsp),
        .snp_in        (local_snp),
        .snp_out       (local_snp_rsp),
        .snp_addr      (snp_addr),
        .snp_hit       (snp_hit),
        .snp_state     (snp_state),
        .snp_data      (snp_data),
        .snp_upd       (snp_upd),
        .snp_new_state (snp_new_state),
        .bus_req       (bus_req),
        .bus_rsp       (bus_rsp)
    );

    bus_ctrl bus_ctrl_inst (
        .CLK            (CLK),
        .rst_n          (rst_n),
        .bus_req        (bus_req),
        .bus_rsp        (bus_rsp),
        .local_snp      (local_snp),
        .local_snp_rsp  (local_snp_rsp),
        .peer_req       (peer_req),
        .peer_rsp       (peer_rsp),
        .peer_snoop     (peer_snoop),
        .peer_snoop_rsp (peer_snoop_rsp),
        .l2_req         (l2_req),
        .l2_state       (l2_state),
        .l2_load        (l2_load)
    );

endmodule

//--- bench/tb_cache_coh.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Testbench for the coherent L1 data cache
//   L2 word model with random stalls
//   peer snoop model, MESI reference model
//   stimulus table applied in a loop
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module tb_cache_coh;
    import coh_pkg::*;

    typedef enum logic [1:0] {CPU_RD, CPU_WR, PEER_RD, PEER_WR} op_t;
    // One table row with its stimulus and the expected bus traffic
    typedef struct packed {
        op_t        op;
        addr_t      addr;
        word_t      wdata;
        // Peer state and data for this row
        mesi_t      pst;
        block_t     pdata;
        // Expected snoop op, first L2 op and beat counts
        bus_op_t    snp_op;
        bus_op_t    l2_first;
        logic [3:0] n_rd;
        logic [3:0] n_wr;
    } row_t;

    localparam int NUM_ROWS = 12;
    localparam int TIMEOUT  = 300;

    logic       CLK;
    logic       rst_n;
    cpu_req_t   cpu_req;
    cpu_rsp_t   cpu_rsp;
    snoop_req_t peer_req;
    snoop_rsp_t peer_rsp;
    snoop_req_t peer_snoop;
    snoop_rsp_t peer_snoop_rsp;
    l2_req_t    l2_req;
    l2_state_t  l2_state;
    word_t      l2_load;

    row_t    rows [NUM_ROWS];
    word_t   l2_mem [256];
    bus_op_t l2_log[$];
    bus_op_t snp_log[$];
    addr_t   snp_addr_log[$];
    logic [31:0] rng = 32'd40672;
    int      stall;
    mesi_t   peer_st;
    block_t  peer_data;
    // Reference model with one entry per set
    mesi_t   ref_st [8];
    logic [25:0] ref_tag [8];
    block_t  ref_data [8];

    cache_coh_top cache_coh_top_inst (
        .CLK(CLK), .rst_n(rst_n), .cpu_req(cpu_req), .cpu_rsp(cpu_rsp),
        .peer_req(peer_req), .peer_rsp(peer_rsp), .peer_snoop(peer_snoop),
        .peer_snoop_rsp(peer_snoop_rsp), .l2_req(l2_req), .l2_state(l2_state),
        .l2_load(l2_load)
    );

    initial begin
        CLK = 1'b0;
        forever #5 CLK = ~CLK;
    end

    function automatic logic [31:0] xorshift();
        rng = rng ^ (rng << 13);
        rng = rng ^ (rng >> 17);
        rng = rng ^ (rng << 5);
        return rng;
    endfunction

    // Two-word line from the L2 model, word 0 at the lower address
    function automatic block_t mem_block(input addr_t base);
        return {l2_mem[base[9:2] + 8'd1], l2_mem[base[9:2]]};
    endfunction

    task automatic report_failure(input string msg);
        $display("%s", msg);
        $display("Simulation failed");
        $fatal(1);
    endtask

    task automatic check_word(input string name, input word_t got, input word_t exp);
        if (got !== exp)
            report_failure($sformatf("ERR t=%0t %s got %h exp %h", $time, name, got, exp));
    endtask

    task automatic check_block(input string name, input block_t got, input block_t exp);
        if (got !== exp)
            report_failure($sformatf("ERR t=%0t %s got %h exp %h", $time, name, got, exp));
    endtask

    task automatic check_op(input string name, input bus_op_t got, input bus_op_t exp);
        if (got !== exp)
            report_failure($sformatf("ERR t=%0t %s got %s exp %s", $time, name,
                                     got.name(), exp.name()));
    endtask

    // L2 word read in the ACCESS cycle
    assign l2_load = l2_mem[l2_req.addr[9:2]];

    // L2 beats with random BUSY cycles before one ACCESS cycle
    initial begin
        for (int i = 0; i < 256; i++)
            l2_mem[i] = (32'(i) << 2) * 32'h0100_0193 ^ 32'hA5A5_0000;
        l2_state = L2_FREE;
        stall = 0;
        forever begin
            @(posedge CLK);
            #1;
            if (l2_state == L2_ACCESS) begin
                l2_state = L2_FREE;
            end else if (l2_req.ren || l2_req.wen) begin
                // New stall count at the start of each beat
                if (l2_state == L2_FREE)
                    stall = int'(xorshift() % 3);
                if (stall == 0) begin
                    l2_state = L2_ACCESS;
                end else begin
                    l2_state = L2_BUSY;
                    stall--;
                end
            end
        end
    end

    // Beat bookkeeping where the request is stable
    always @(negedge CLK) begin
        if (l2_state == L2_ACCESS && l2_req.wen) begin
            l2_mem[l2_req.addr[9:2]] = l2_req.store;
            l2_log.push_back(BUS_WB);
        end else if (l2_state == L2_ACCESS && l2_req.ren) begin
            l2_log.push_back(BUS_RD);
        end
    end

    // Peer answers each outbound snoop from its table state
    initial begin
        peer_snoop_rsp = '0;
        forever begin
            @(posedge CLK);
            #1;
            if (peer_snoop_rsp.done) begin
                peer_snoop_rsp = '0;
            end else if (peer_snoop.valid) begin
                peer_snoop_rsp.done  = 1'b1;
                peer_snoop_rsp.hit   = (peer_st != INVALID);
                peer_snoop_rsp.dirty = (peer_st == MODIFIED);
                peer_snoop_rsp.data  = peer_data;
                snp_log.push_back(peer_snoop.write ? BUS_RDX : BUS_RD);
                // Peer tracks whole lines by block address
                snp_addr_log.push_back({peer_snoop.addr[31:3], 3'b000});
            end
        end
    end

    task automatic cpu_access(input op_t op, input addr_t addr, input word_t wdata,
                              output word_t rdata);
        int n;
        n = 0;
        cpu_req.ren   = (op == CPU_RD);
        cpu_req.wen   = (op == CPU_WR);
        cpu_req.addr  = addr;
        cpu_req.wdata = wdata;
        forever begin
            @(negedge CLK);
            if (!cpu_rsp.busy)
                break;
            n++;
            if (n > TIMEOUT)
                report_failure("Processor request never completed");
        end
        rdata = cpu_rsp.rdata;
        @(posedge CLK);
        #1;
        cpu_req = '0;
    endtask

    task automatic peer_access(input op_t op, input addr_t addr, output snoop_rsp_t rsp);
        int n;
        n = 0;
        peer_req.valid = 1'b1;
        peer_req.write = (op == PEER_WR);
        peer_req.addr  = addr;
        forever begin
            @(negedge CLK);
            if (peer_rsp.done)
                break;
            n++;
            if (n > TIMEOUT)
                report_failure("Peer request was never answered");
        end
        rsp = peer_rsp;
        @(posedge CLK);
        #1;
        peer_req = '0;
    endtask

    task automatic apply_row(input row_t r);
        index_t     idx;
        logic [25:0] tag;
        addr_t      base;
        logic       hit;
        logic       wb;
        addr_t      wb_base;
        block_t     wb_blk;
        word_t      rdata;
        snoop_rsp_t rsp;
        int         l2_0;
        int         snp_0;
        int         n_rd;
        int         n_wr;
        idx  = r.addr[5:3];
        tag  = r.addr[31:6];
        base = {r.addr[31:3], 3'b000};
        hit  = (ref_st[idx] != INVALID) && (ref_tag[idx] == tag);
        wb   = 1'b0;
        wb_base = base;
        wb_blk  = '0;
        peer_st   = r.pst;
        peer_data = r.pdata;
        l2_0  = l2_log.size();
        snp_0 = snp_log.size();
        if (r.op == CPU_RD || r.op == CPU_WR) begin
            if (!hit) begin
                // Dirty victim goes out first
                if (ref_st[idx] == MODIFIED) begin
                    wb = 1'b1;
                    wb_base = {ref_tag[idx], idx, 3'b000};
                    wb_blk  = ref_data[idx];
                end
                ref_data[idx] = (r.pst != INVALID) ? r.pdata : mem_block(base);
                ref_tag[idx]  = tag;
                ref_st[idx]   = (r.pst != INVALID) ? SHARED : EXCLUSIVE;
                // Dirty peer data also lands in L2
                if (r.pst == MODIFIED) begin
                    wb = 1'b1;
                    wb_blk = r.pdata;
                end
            end
            if (r.op == CPU_WR) begin
                ref_st[idx] = MODIFIED;
                ref_data[idx][r.addr[2]] = r.wdata;
            end
            cpu_access(r.op, r.addr, r.wdata, rdata);
            if (r.op == CPU_RD)
                check_word("cpu_rsp.rdata", rdata, ref_data[idx][r.addr[2]]);
        end else begin
            wb_blk = ref_data[idx];
            wb = hit && (ref_st[idx] == MODIFIED);
            peer_access(r.op, r.addr, rsp);
            check_word("peer_rsp.hit", word_t'(rsp.hit), word_t'(hit));
            // Only a hit on a Modified line reports dirty
            check_word("peer_rsp.dirty", word_t'(rsp.dirty), word_t'(wb));
            if (hit) begin
                check_block("peer_rsp.data", rsp.data, wb_blk);
                ref_st[idx] = (r.op == PEER_RD) ? SHARED : INVALID;
            end
        end
        // Bus traffic seen during this row
        check_word("peer_snoop count", word_t'(snp_log.size() - snp_0),
                   word_t'(r.snp_op != BUS_NONE));
        if (r.snp_op != BUS_NONE) begin
            check_op("peer_snoop op", snp_log[snp_0], r.snp_op);
            check_word("peer_snoop.addr", snp_addr_log[snp_0], base);
        end
        n_rd = 0;
        n_wr = 0;
        for (int i = l2_0; i < l2_log.size(); i++) begin
            if (l2_log[i] == BUS_RD)
                n_rd++;
            else
                n_wr++;
        end
        check_word("l2 read beats", word_t'(n_rd), word_t'(r.n_rd));
        check_word("l2 write beats", word_t'(n_wr), word_t'(r.n_wr));
        if (r.l2_first != BUS_NONE)
            check_op("first l2 op", l2_log[l2_0], r.l2_first);
        if (wb)
            check_block("l2 written block", mem_block(wb_base), wb_blk);
    endtask

    initial begin
        rst_n    = 1'b0;
        cpu_req  = '0;
        peer_req = '0;
        peer_st  = INVALID;
        peer_data = '0;
        for (int i = 0; i < 8; i++) begin
            ref_st[i]   = INVALID;
            ref_tag[i]  = '0;
            ref_data[i] = '0;
        end
        // Fill, Exclusive hit, c2c Shared fill and upgrade, write miss
        rows[0]  = '{CPU_RD,  32'h100, 32'h0, INVALID, '0, BUS_RD, BUS_RD, 2, 0};
        rows[1]  = '{CPU_RD,  32'h104, 32'h0, INVALID, '0, BUS_NONE, BUS_NONE, 0, 0};
        rows[2]  = '{CPU_RD,  32'h048, 32'h0, SHARED, {32'hB1B1_0001, 32'hB0B0_0000},
                     BUS_RD, BUS_NONE, 0, 0};
        rows[3]  = '{CPU_WR,  32'h04C, 32'h1234_5678, SHARED, {32'hB1B1_0001, 32'hB0B0_0000},
                     BUS_RDX, BUS_NONE, 0, 0};
        rows[4]  = '{CPU_RD,  32'h04C, 32'h0, INVALID, '0, BUS_NONE, BUS_NONE, 0, 0};
        rows[5]  = '{CPU_WR,  32'h090, 32'hCAFE_F00D, INVALID, '0, BUS_RDX, BUS_RD, 2, 0};
        rows[6]  = '{CPU_RD,  32'h090, 32'h0, INVALID, '0, BUS_NONE, BUS_NONE, 0, 0};
        // Peer reads of a Modified line, then eviction and invalidation
        rows[7]  = '{PEER_RD, 32'h090, 32'h0, INVALID, '0, BUS_NONE, BUS_WB, 0, 2};
        rows[8]  = '{PEER_RD, 32'h090, 32'h0, INVALID, '0, BUS_NONE, BUS_NONE, 0, 0};
        rows[9]  = '{CPU_RD,  32'h248, 32'h0, INVALID, '0, BUS_RD, BUS_WB, 2, 2};
        rows[10] = '{PEER_WR, 32'h090, 32'h0, INVALID, '0, BUS_NONE, BUS_NONE, 0, 0};
        rows[11] = '{CPU_RD,  32'h094, 32'h0, MODIFIED, {32'hD1D1_0001, 32'hD0D0_0000},
                     BUS_RD, BUS_WB, 0, 2};
        repeat (16) @(posedge CLK);
        #1;
        rst_n = 1'b1;
        for (int i = 0; i < NUM_ROWS; i++)
            apply_row(rows[i]);
        $display("Simulation passed");
        $finish;
    end

endmodule

//--- compile.f
+incdir+common
common/coh_pkg.sv
l1_cache/l1_dcache.sv
l1_cache/coherence_unit.sv
logic/bus_ctrl.sv
logic/cache_coh_top.sv
bench/tb_cache_coh.sv

//--- Makefile
# Verilator build and run of the coherence testbench

.PHONY: all build lint clean

all: build
	./obj_dir/Vtb_cache_coh | tee sim.log
	grep -q "Simulation passed" sim.log

build:
	verilator --binary --timing -f compile.f --top-module tb_cache_coh -o Vtb_cache_coh

lint:
	verilator --lint-only --timing -f compile.f --top-module cache_coh_top

clean:
	rm -rf obj_dir sim.log
